// File: logic/byte_bank.sv
/*
 * One byte-wide RAM bank, selected by LANE.
 * Synchronous write and registered read; a read and a write to the same
 * address in one cycle return the previous byte.
 */
`timescale 1ns/1ps
`include "mem_cfg.svh"

module byte_bank
    import mem_lane_pkg::*;
#(
    parameter int LANE = 0  // Which lane of the bus this bank serves
) (
    input  logic           clk,
    lane_bus_if.bank       i_lanes,
    output lane_byte_t     o_byte
);

    localparam int DEPTH = 2 ** (`MEM_ADDR_W - 2);

    lane_byte_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_lanes.wmask[LANE]) begin
            mem[i_lanes.waddr[LANE]] <= i_lanes.wbyte[LANE];
        end
    end

    // Nonblocking read sees the old contents
    always_ff @(posedge clk) begin
        if (i_lanes.ren) begin
            o_byte <= mem[i_lanes.raddr[LANE]];
        end
    end

endmodule

// File: logic/data_mem.sv
/*
 * Byte-addressed data memory for loads and stores of a small RISC-V core.
 * Separate write and read ports; load data appears two edges after i_ren.
 */
`timescale 1ns/1ps
`include "mem_cfg.svh"

module data_mem
    import mem_access_pkg::*;
    import mem_lane_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_wen,
    input  mem_addr_t i_waddr,
    input  mem_size_e i_wsize,
    input  mem_word_t i_wdata,
    input  logic      i_ren,
    input  mem_addr_t i_raddr,
    input  mem_size_e i_rsize,
    input  mem_sign_t i_rsigned,
    output mem_word_t o_dout
);

    lane_idx_t  rd_off;
    mem_size_e  rd_size;
    mem_sign_t  rd_signed;
    logic       rd_valid;
    lane_byte_t bank_bytes [`MEM_LANES];

    lane_bus_if u_lanes ();

    store_lane_steer u_steer (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_wen     (i_wen),
        .i_waddr   (i_waddr),
        .i_wsize   (i_wsize),
        .i_wdata   (i_wdata),
        .i_ren     (i_ren),
        .i_raddr   (i_raddr),
        .i_rsize   (i_rsize),
        .i_rsigned (i_rsigned),
        .o_lanes   (u_lanes.steer),
        .o_roff    (rd_off),
        .o_rsize   (rd_size),
        .o_rsigned (rd_signed),
        .o_rvalid  (rd_valid)
    );

    for (genvar i = 0; i < `MEM_LANES; i++) begin : g_bank
        byte_bank #(
            .LANE (i)
        ) u_bank (
            .clk     (clk),
            .i_lanes (u_lanes.bank),
            .o_byte  (bank_bytes[i])
        );
    end

    load_lane_align u_align (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_bytes   (bank_bytes),
        .i_roff    (rd_off),
        .i_rsize   (rd_size),
        .i_rsigned (rd_signed),
        .i_rvalid  (rd_valid),
        .o_dout    (o_dout)
    );

endmodule

// File: logic/lane_bus_if.sv
/*
 * Per-lane write and read controls from the store steering logic to the banks.
 * The steer side drives everything; each bank picks out its own lane.
 */
`timescale 1ns/1ps
`include "mem_cfg.svh"

interface lane_bus_if
    import mem_lane_pkg::*;
();

    lane_mask_t wmask;                    // Lanes written this cycle
    lane_addr_t waddr [`MEM_LANES];
    lane_byte_t wbyte [`MEM_LANES];       // Already rotated into lane order
    lane_addr_t raddr [`MEM_LANES];
    logic       ren;

    modport steer (
        output wmask,
        output waddr,
        output wbyte,
        output raddr,
        output ren
    );

    modport bank (
        input wmask,
        input waddr,
        input wbyte,
        input raddr,
        input ren
    );

endinterface

// File: logic/load_lane_align.sv
/*
 * Load side of the data memory.
 * Rotates the bank bytes so the addressed byte lands in bits 7:0, then
 * zero- or sign-extends by load size and registers the result.
 */
`timescale 1ns/1ps
`include "mem_cfg.svh"

module load_lane_align
    import mem_access_pkg::*;
    import mem_lane_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,
    input  lane_byte_t i_bytes [`MEM_LANES],
    input  lane_idx_t  i_roff,
    input  mem_size_e  i_rsize,
    input  mem_sign_t  i_rsigned,
    input  logic       i_rvalid,
    output mem_word_t  o_dout
);

    mem_word_t bank_word;
    mem_word_t rot_word;
    mem_word_t ext_word;
    logic      sign_bit;

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            bank_word[i*`MEM_LANE_W +: `MEM_LANE_W] = i_bytes[i];
        end
    end

    // Rotate right by the byte offset
    assign rot_word = mem_word_t'({bank_word, bank_word} >> (i_roff * `MEM_LANE_W));

    always_comb begin
        sign_bit = 1'b0;
        case (i_rsize)
            BYTE: begin
                sign_bit = i_rsigned & rot_word[7];
                ext_word = {{24{sign_bit}}, rot_word[7:0]};
            end
            HALF: begin
                sign_bit = i_rsigned & rot_word[15];
                ext_word = {{16{sign_bit}}, rot_word[15:0]};
            end
            WORD:    ext_word = rot_word;
            default: ext_word = '0;  // No access size
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_dout <= '0;
        end else if (i_rvalid) begin
            o_dout <= ext_word;
        end
    end

    // Output only moves on the edge after a read reached the banks
    a_dout_hold: assert property (@(posedge clk) disable iff (i_rst)
        !$past(i_rvalid) |-> $stable(o_dout));

endmodule

// File: logic/mem_access_pkg.sv
/*
 * CPU-side view of a memory access.
 * Access size, sign flag, data word and byte address types.
 */
`include "mem_cfg.svh"

package mem_access_pkg;

    // Load/store width, encoded as in the core
    typedef enum logic [1:0] {
        NONE = 2'd0,
        BYTE = 2'd1,
        HALF = 2'd2,
        WORD = 2'd3
    } mem_size_e;

    typedef logic mem_sign_t;  // High for LB/LH, low for LBU/LHU

    typedef logic [`MEM_LANES*`MEM_LANE_W-1:0] mem_word_t;
    typedef logic [`MEM_ADDR_W-1:0]            mem_addr_t;

endpackage

// File: logic/mem_cfg.svh
/*
 * Size settings for the byte-banked data memory.
 * Included by the packages and by every RTL file that sizes its own vectors.
 */
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

`define MEM_ADDR_W 8   // Byte address width
`define MEM_LANES  4   // Byte lanes per word
`define MEM_LANE_W 8   // Bits per lane

`endif

// File: logic/mem_lane_pkg.sv
/*
 * Bank-side view of the memory.
 * Types for lane masks, byte offsets, per-bank word addresses and stored bytes.
 */
`include "mem_cfg.svh"

package mem_lane_pkg;

    // One write enable per byte bank
    typedef logic [`MEM_LANES-1:0] lane_mask_t;

    // Byte offset inside a word
    typedef logic [$clog2(`MEM_LANES)-1:0] lane_idx_t;

    // Word address seen by each bank
    typedef logic [`MEM_ADDR_W-3:0] lane_addr_t;

    typedef logic [`MEM_LANE_W-1:0] lane_byte_t;

endpackage

// File: logic/store_lane_steer.sv
/*
 * Maps byte addresses and access sizes onto the four byte banks.
 * Lanes below the byte offset go to the next word; the read offset and size
 * are held one cycle so they meet the bank output at the aligner.
 */
`timescale 1ns/1ps
`include "mem_cfg.svh"

module store_lane_steer
    import mem_access_pkg::*;
    import mem_lane_pkg::*;
(
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_wen,
    input  mem_addr_t        i_waddr,
    input  mem_size_e        i_wsize,
    input  mem_word_t        i_wdata,
    input  logic             i_ren,
    input  mem_addr_t        i_raddr,
    input  mem_size_e        i_rsize,
    input  mem_sign_t        i_rsigned,
    lane_bus_if.steer        o_lanes,
    output lane_idx_t        o_roff,
    output mem_size_e        o_rsize,
    output mem_sign_t        o_rsigned,
    output logic             o_rvalid
);

    lane_idx_t  w_off;
    lane_idx_t  r_off;
    lane_addr_t w_word;
    lane_addr_t r_word;
    lane_mask_t w_smask;
    mem_word_t  w_rot;

    // Lanes touched by an access at offset zero
    function automatic lane_mask_t size_mask(input mem_size_e size);
        case (size)
            BYTE:    size_mask = lane_mask_t'(1);
            HALF:    size_mask = lane_mask_t'(3);
            WORD:    size_mask = '1;
            default: size_mask = '0;
        endcase
    endfunction

    assign w_off   = i_waddr[1:0];
    assign r_off   = i_raddr[1:0];
    assign w_word  = i_waddr[`MEM_ADDR_W-1:2];
    assign r_word  = i_raddr[`MEM_ADDR_W-1:2];
    assign w_smask = size_mask(i_wsize);

    // Rotate left by the offset, upper half of the doubled word
    assign w_rot = mem_word_t'(({i_wdata, i_wdata} << (w_off * `MEM_LANE_W)) >> $bits(mem_word_t));

    always_comb begin
        o_lanes.wmask = '0;
        for (int i = 0; i < `MEM_LANES; i++) begin
            if (i_wen)
                o_lanes.wmask[(i + w_off) % `MEM_LANES] = w_smask[i];
            // Lanes below the offset wrap into the next word
            o_lanes.waddr[i] = w_word + lane_addr_t'(i < w_off);
            o_lanes.raddr[i] = r_word + lane_addr_t'(i < r_off);
            o_lanes.wbyte[i] = w_rot[i*`MEM_LANE_W +: `MEM_LANE_W];
        end
        o_lanes.ren = i_ren;
    end

    // Read attributes travel alongside the bank read
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_roff    <= '0;
            o_rsize   <= NONE;
            o_rsigned <= 1'b0;
            o_rvalid  <= 1'b0;
        end else begin
            o_rvalid <= i_ren;
            if (i_ren) begin
                o_roff    <= r_off;
                o_rsize   <= i_rsize;
                o_rsigned <= i_rsigned;
            end
        end
    end

    a_wsize_valid: assert property (@(posedge clk) disable iff (i_rst)
        i_wen |-> i_wsize != NONE);

    a_rsize_valid: assert property (@(posedge clk) disable iff (i_rst)
        i_ren |-> i_rsize != NONE);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the data memory testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_data_mem \
    -o sim_tb_data_mem > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/sim_tb_data_mem > "$SIM_LOG" 2>&1 \
    || { cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$SIM_LOG"
grep -q "TESTBENCH FAILED" "$SIM_LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" "$SIM_LOG" || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: test/tb_data_mem.sv
/*
 * Testbench for the byte-banked data memory.
 * Builds a table of write/read steps, applies it on falling edges and checks
 * o_dout every cycle against a flat reference byte array.
 */
`timescale 1ns/1ps
`include "mem_cfg.svh"

module tb_data_mem
    import mem_access_pkg::*;
    import mem_lane_pkg::*;
();

    localparam int MEM_BYTES   = 2 ** `MEM_ADDR_W;
    localparam int DRAIN_LIMIT = 10;

    typedef struct packed {
        logic      wen;
        mem_addr_t waddr;
        mem_size_e wsize;
        mem_word_t wdata;
        logic      ren;
        mem_addr_t raddr;
        mem_size_e rsize;
        mem_sign_t rsigned;
    } step_t;

    logic      clk;
    logic      i_rst;
    logic      i_wen;
    mem_addr_t i_waddr;
    mem_size_e i_wsize;
    mem_word_t i_wdata;
    logic      i_ren;
    mem_addr_t i_raddr;
    mem_size_e i_rsize;
    mem_sign_t i_rsigned;
    mem_word_t o_dout;

    lane_byte_t ref_mem [MEM_BYTES];  // Byte-addressed model of the memory
    step_t      steps [$];
    mem_word_t  exp_q [$];            // Expected load words, oldest first
    int         due_q [$];            // Cycle at which each one shows up
    mem_word_t  exp_dout;
    int         cyc;
    int         n_checks;
    int         n_errors;
    int         n_timeouts;

    data_mem i_dut (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_wen     (i_wen),
        .i_waddr   (i_waddr),
        .i_wsize   (i_wsize),
        .i_wdata   (i_wdata),
        .i_ren     (i_ren),
        .i_raddr   (i_raddr),
        .i_rsize   (i_rsize),
        .i_rsigned (i_rsigned),
        .o_dout    (o_dout)
    );

    always #4 clk = ~clk;

    function automatic int size_bytes(input mem_size_e size);
        case (size)
            BYTE:    return 1;
            HALF:    return 2;
            WORD:    return 4;
            default: return 0;
        endcase
    endfunction

    // Consecutive byte addresses, little endian, wrapping at the top
    function automatic void ref_store(input mem_addr_t addr, input mem_size_e size,
                                     input mem_word_t data);
        int nbytes;
        nbytes = size_bytes(size);
        for (int b = 0; b < nbytes; b++) begin
            ref_mem[mem_addr_t'(addr + b)] = data[b*8 +: 8];
        end
    endfunction

    function automatic mem_word_t ref_load(input mem_addr_t addr, input mem_size_e size,
                                           input mem_sign_t sgn);
        mem_word_t w;
        int        nbytes;
        w      = '0;
        nbytes = size_bytes(size);
        for (int b = 0; b < nbytes; b++) begin
            w[b*8 +: 8] = ref_mem[mem_addr_t'(addr + b)];
        end
        // Copy the top loaded bit upward for LB/LH
        if (sgn && nbytes < 4 && w[nbytes*8-1]) begin
            for (int k = nbytes * 8; k < 32; k++) begin
                w[k] = 1'b1;
            end
        end
        return w;
    endfunction

    task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %s got 0x%08h expected 0x%08h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic push_step(input logic wen, input mem_addr_t waddr, input mem_size_e wsize,
                             input mem_word_t wdata, input logic ren, input mem_addr_t raddr,
                             input mem_size_e rsize, input mem_sign_t rsigned);
        steps.push_back('{wen, waddr, wsize, wdata, ren, raddr, rsize, rsigned});
    endtask

    task automatic store_entry(input mem_addr_t addr, input mem_size_e size, input mem_word_t data);
        push_step(1'b1, addr, size, data, 1'b0, '0, NONE, 1'b0);
    endtask

    task automatic load_entry(input mem_addr_t addr, input mem_size_e size, input mem_sign_t sgn);
        push_step(1'b0, '0, NONE, '0, 1'b1, addr, size, sgn);
    endtask

    task automatic idle_entry();
        push_step(1'b0, '0, NONE, '0, 1'b0, '0, NONE, 1'b0);
    endtask

    // Check this cycle's output, then drive one step and move to the next falling edge
    task automatic run_step(input step_t s);
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            exp_dout = exp_q.pop_front();
            void'(due_q.pop_front());
        end
        check_word("o_dout", o_dout, exp_dout);
        i_wen     = s.wen;
        i_waddr   = s.waddr;
        i_wsize   = s.wsize;
        i_wdata   = s.wdata;
        i_ren     = s.ren;
        i_raddr   = s.raddr;
        i_rsize   = s.rsize;
        i_rsigned = s.rsigned;
        if (s.ren) begin
            exp_q.push_back(ref_load(s.raddr, s.rsize, s.rsigned));  // Old data on a collision
            due_q.push_back(cyc + 2);
        end
        if (s.wen) begin
            ref_store(s.waddr, s.wsize, s.wdata);
        end
        cyc++;
        @(negedge clk);
    endtask

    initial begin
        step_t     idle;
        mem_addr_t a;
        int        drain;
        clk        = 1'b0;
        i_rst      = 1'b1;
        i_wen      = 1'b0;
        i_waddr    = '0;
        i_wsize    = NONE;
        i_wdata    = '0;
        i_ren      = 1'b0;
        i_raddr    = '0;
        i_rsize    = NONE;
        i_rsigned  = 1'b0;
        exp_dout   = '0;
        cyc        = 0;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        idle       = '{1'b0, '0, NONE, '0, 1'b0, '0, NONE, 1'b0};
        void'($urandom(32'h3c4de9d3));

        repeat (2) idle_entry();  // Output must sit at zero
        for (int i = 0; i < MEM_BYTES; i += 4) begin
            store_entry(mem_addr_t'(i), WORD, $urandom());
        end
        for (int i = 0; i < MEM_BYTES; i += 4) begin
            load_entry(mem_addr_t'(i), WORD, 1'b0);  // Back to back
        end

        // Narrow stores at every offset, last halfword spills into 0x60
        for (int off = 0; off < 4; off++) begin
            store_entry(mem_addr_t'(8'h40 + 5 * off), BYTE, $urandom());
            store_entry(mem_addr_t'(8'h50 + 5 * off), HALF, $urandom());
        end
        for (int i = 8'h3c; i <= 8'h64; i += 4) begin
            load_entry(mem_addr_t'(i), WORD, 1'b0);
        end

        // Mixed sign bits for the extension loads
        store_entry(8'h20, WORD, 32'h8f70_f115);
        store_entry(8'h24, WORD, 32'h0ca3_5eb6);
        for (int off = 0; off < 4; off++) begin
            for (int sgn = 0; sgn < 2; sgn++) begin
                load_entry(mem_addr_t'(8'h20 + off), BYTE, mem_sign_t'(sgn));
                load_entry(mem_addr_t'(8'h20 + off), HALF, mem_sign_t'(sgn));
            end
        end

        // Same-word read and write in one cycle, then a fresh read
        for (int k = 0; k < 8; k++) begin
            a = mem_addr_t'($urandom()) & 8'hfc;
            push_step(1'b1, a, WORD, $urandom(), 1'b1, a, WORD, 1'b0);
            load_entry(a, WORD, 1'b0);
        end

        repeat (4) @(negedge clk);
        i_rst = 1'b0;

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        drain = 0;
        while (due_q.size() != 0 && drain < DRAIN_LIMIT) begin
            run_step(idle);
            drain++;
        end
        if (due_q.size() != 0) begin
            n_timeouts++;
            $display("Timed out with %0d load results still pending", due_q.size());
        end

        $display("checks=%0d errors=%0d timeouts=%0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/mem_access_pkg.sv
logic/mem_lane_pkg.sv
logic/lane_bus_if.sv
logic/store_lane_steer.sv
logic/byte_bank.sv
logic/load_lane_align.sv
logic/data_mem.sv
test/tb_data_mem.sv
